/* hw/sw_pkg.sv */
`default_nettype none

package sw_pkg;

    // array sizes
    localparam int REF_MAX_LEN  = 16;
    localparam int READ_MAX_LEN = 8;
    localparam int SCORE_W      = 10;

    // 2-bit nucleotide code
    typedef logic [1:0] base_t;

    typedef logic signed [SCORE_W-1:0] score_t;

    // packed sequences, base 0 at the msb end
    typedef logic [2*REF_MAX_LEN-1:0]  ref_seq_t;
    typedef logic [2*READ_MAX_LEN-1:0] read_seq_t;

    // lengths are 1-based
    typedef logic [4:0] ref_len_t;
    typedef logic [3:0] read_len_t;

    typedef logic [3:0] col_t;
    typedef logic [2:0] row_t;

    // affine gap scoring
    localparam score_t MATCH_SCORE    = 1;
    localparam score_t MISMATCH_SCORE = -4;
    localparam score_t GAP_OPEN       = -6;
    localparam score_t GAP_EXTEND     = -1;

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_LOAD,
        FEED_CALC,
        FEED_WAIT
    } feed_state_t;

endpackage

`default_nettype wire

/* hw/pe_link_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface pe_link_if import sw_pkg::*; ();

    logic   a_valid;
    base_t  a_base;
    score_t h;
    score_t e;
    // H of the previous column, for the diagonal term below
    score_t h_diag;

    modport up (
        output a_valid,
        output a_base,
        output h,
        output e,
        output h_diag
    );

    modport down (
        input a_valid,
        input a_base,
        input h,
        input e,
        input h_diag
    );

endinterface

`default_nettype wire

/* hw/sw_feeder.sv */
`timescale 1ns/10ps
`default_nettype none

module sw_feeder import sw_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            i_valid,
    input  wire ref_seq_t  i_sequence_ref,
    input  wire read_seq_t i_sequence_read,
    input  wire ref_len_t  i_ref_len,
    input  wire read_len_t i_read_len,
    input  wire            i_release,
    output logic           o_ready,
    output logic           o_clear,
    output logic           o_row_valid [READ_MAX_LEN],
    output base_t          o_read_base [READ_MAX_LEN],
    output read_len_t      o_read_len,
    output logic           o_scan_start,
    pe_link_if.up          link
);

    feed_state_t state;
    feed_state_t state_nxt;
    ref_seq_t    ref_sh;
    read_seq_t   read_q;
    ref_len_t    ref_len_q;
    read_len_t   read_len_q;
    logic [4:0]  cyc_cnt;
    logic [4:0]  calc_last;
    logic        job_accept;
    logic        calc_done;

    assign job_accept = (state == FEED_IDLE) && i_valid;

    // last base leaves the bottom row after ref_len + read_len cycles
    assign calc_last = ref_len_q + 5'(read_len_q) - 5'd1;
    assign calc_done = (state == FEED_CALC) && (cyc_cnt == calc_last);

    always_comb begin
        state_nxt = state;
        case (state)
            FEED_IDLE: if (i_valid) state_nxt = FEED_LOAD;
            FEED_LOAD: state_nxt = FEED_CALC;
            FEED_CALC: if (calc_done) state_nxt = FEED_WAIT;
            FEED_WAIT: if (i_release) state_nxt = FEED_IDLE;
            default:   state_nxt = FEED_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FEED_IDLE;
            cyc_cnt    <= '0;
            ref_len_q  <= '0;
            read_len_q <= '0;
        end else begin
            state <= state_nxt;
            if (job_accept) begin
                ref_len_q  <= i_ref_len;
                read_len_q <= i_read_len;
            end
            if (state == FEED_CALC) begin
                cyc_cnt <= cyc_cnt + 5'd1;
            end else begin
                cyc_cnt <= '0;
            end
        end
    end

    // reference shifts out one base per calc cycle
    always_ff @(posedge clk) begin
        if (job_accept) begin
            ref_sh <= i_sequence_ref;
            read_q <= i_sequence_read;
        end else if (state == FEED_CALC) begin
            ref_sh <= ref_sh << 2;
        end
    end

    always_comb begin
        for (int k = 0; k < READ_MAX_LEN; k++) begin
            o_row_valid[k] = (k < int'(read_len_q));
            o_read_base[k] = read_q[2*READ_MAX_LEN-1-2*k -: 2];
        end
    end

    assign o_ready      = (state == FEED_IDLE);
    assign o_clear      = (state == FEED_LOAD);
    assign o_scan_start = calc_done;
    assign o_read_len   = read_len_q;

    // row above the first PE is all zero
    assign link.a_valid = (state == FEED_CALC) && (cyc_cnt < ref_len_q);
    assign link.a_base  = ref_sh[2*REF_MAX_LEN-1 -: 2];
    assign link.h       = '0;
    assign link.e       = '0;
    assign link.h_diag  = '0;

endmodule

`default_nettype wire

/* hw/sw_pe.sv */
`timescale 1ns/10ps
`default_nettype none

module sw_pe import sw_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        i_clear,
    input  wire        i_row_valid,
    input  wire base_t i_read_base,
    pe_link_if.down    up,
    pe_link_if.up      down,
    output score_t     o_row_best,
    output col_t       o_row_best_col
);

    logic   calc;
    logic   a_valid_q;
    base_t  a_base_q;
    score_t h_q;
    score_t h_prev_q;
    score_t e_q;
    score_t f_q;
    score_t sub_score;
    score_t e_new;
    score_t f_new;
    score_t h_new;
    score_t row_best_q;
    col_t   row_best_col_q;
    col_t   col_cnt;

    function automatic score_t max_of(input score_t a, input score_t b);
        return (a > b) ? a : b;
    endfunction

    assign calc = up.a_valid && i_row_valid;

    always_comb begin
        sub_score = (up.a_base == i_read_base) ? MATCH_SCORE : MISMATCH_SCORE;
        // gap along the read from the row above
        e_new = max_of(max_of('0, up.h + GAP_OPEN), up.e + GAP_EXTEND);
        // gap along the reference from our previous column
        f_new = max_of(max_of('0, h_q + GAP_OPEN), f_q + GAP_EXTEND);
        h_new = max_of(max_of('0, up.h_diag + sub_score), max_of(e_new, f_new));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_q            <= '0;
            h_prev_q       <= '0;
            e_q            <= '0;
            f_q            <= '0;
            row_best_q     <= '0;
            row_best_col_q <= '0;
            col_cnt        <= '0;
        end else if (i_clear) begin
            h_q            <= '0;
            h_prev_q       <= '0;
            e_q            <= '0;
            f_q            <= '0;
            row_best_q     <= '0;
            row_best_col_q <= '0;
            col_cnt        <= '0;
        end else if (calc) begin
            h_q      <= h_new;
            h_prev_q <= h_q;
            e_q      <= e_new;
            f_q      <= f_new;
            col_cnt  <= col_cnt + 4'd1;
            // strict compare keeps the earliest column on a tie
            if (h_new > row_best_q) begin
                row_best_q     <= h_new;
                row_best_col_q <= col_cnt;
            end
        end
    end

    // reference base moves one PE down per cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_valid_q <= 1'b0;
        end else begin
            a_valid_q <= up.a_valid;
        end
    end

    always_ff @(posedge clk) begin
        a_base_q <= up.a_base;
    end

    assign down.a_valid = a_valid_q;
    assign down.a_base  = a_base_q;
    assign down.h       = h_q;
    assign down.e       = e_q;
    assign down.h_diag  = h_prev_q;

    assign o_row_best     = row_best_q;
    assign o_row_best_col = row_best_col_q;

endmodule

`default_nettype wire

/* hw/sw_max_select.sv */
`timescale 1ns/10ps
`default_nettype none

module sw_max_select import sw_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            i_scan_start,
    input  wire read_len_t i_read_len,
    input  wire score_t    i_row_best [READ_MAX_LEN],
    input  wire col_t      i_row_best_col [READ_MAX_LEN],
    input  wire            i_ready,
    output logic           o_release,
    output logic           o_valid,
    output score_t         o_score,
    output row_t           o_row,
    output col_t           o_column
);

    logic scanning;
    row_t scan_row;
    row_t last_row;

    assign last_row = row_t'(i_read_len - 4'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scanning  <= 1'b0;
            scan_row  <= '0;
            o_valid   <= 1'b0;
            o_release <= 1'b0;
            o_score   <= '0;
            o_row     <= '0;
            o_column  <= '0;
        end else begin
            o_release <= 1'b0;
            if (i_scan_start) begin
                // running best starts at zero so an all-zero job reports row 0 col 0
                scanning <= 1'b1;
                scan_row <= '0;
                o_score  <= '0;
                o_row    <= '0;
                o_column <= '0;
            end else if (scanning) begin
                // first row wins a tie
                if (i_row_best[scan_row] > o_score) begin
                    o_score  <= i_row_best[scan_row];
                    o_row    <= scan_row;
                    o_column <= i_row_best_col[scan_row];
                end
                if (scan_row == last_row) begin
                    scanning <= 1'b0;
                    o_valid  <= 1'b1;
                end else begin
                    scan_row <= scan_row + 3'd1;
                end
            end else if (o_valid && i_ready) begin
                // release lets the feeder go idle
                o_valid   <= 1'b0;
                o_release <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sw_array_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sw_array_top import sw_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            i_valid,
    input  wire ref_seq_t  i_sequence_ref,
    input  wire read_seq_t i_sequence_read,
    input  wire ref_len_t  i_ref_len,
    input  wire read_len_t i_read_len,
    input  wire            i_ready,
    output logic           o_ready,
    output logic           o_valid,
    output score_t         o_score,
    output row_t           o_row,
    output col_t           o_column
);

    logic      clear;
    logic      row_valid [READ_MAX_LEN];
    base_t     read_base [READ_MAX_LEN];
    read_len_t read_len;
    logic      scan_start;
    logic      result_taken;
    score_t    row_best [READ_MAX_LEN];
    col_t      row_best_col [READ_MAX_LEN];

    // link k feeds PE k, the last one hangs open
    pe_link_if link [READ_MAX_LEN+1] ();

    sw_feeder u_feeder (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .i_sequence_ref  (i_sequence_ref),
        .i_sequence_read (i_sequence_read),
        .i_ref_len       (i_ref_len),
        .i_read_len      (i_read_len),
        .i_release       (result_taken),
        .o_ready         (o_ready),
        .o_clear         (clear),
        .o_row_valid     (row_valid),
        .o_read_base     (read_base),
        .o_read_len      (read_len),
        .o_scan_start    (scan_start),
        .link            (link[0])
    );

    for (genvar k = 0; k < READ_MAX_LEN; k++) begin : g_pe
        sw_pe u_pe (
            .clk            (clk),
            .rst            (rst),
            .i_clear        (clear),
            .i_row_valid    (row_valid[k]),
            .i_read_base    (read_base[k]),
            .up             (link[k]),
            .down           (link[k+1]),
            .o_row_best     (row_best[k]),
            .o_row_best_col (row_best_col[k])
        );
    end

    sw_max_select u_select (
        .clk            (clk),
        .rst            (rst),
        .i_scan_start   (scan_start),
        .i_read_len     (read_len),
        .i_row_best     (row_best),
        .i_row_best_col (row_best_col),
        .i_ready        (i_ready),
        .o_release      (result_taken),
        .o_valid        (o_valid),
        .o_score        (o_score),
        .o_row          (o_row),
        .o_column       (o_column)
    );

endmodule

`default_nettype wire

/* include/sw_model.svh */
`ifndef SW_MODEL_SVH
`define SW_MODEL_SVH

function automatic int sw_model_max(input int a, input int b);
    return (a > b) ? a : b;
endfunction

// full DP table, same clamped affine rules as the array
function automatic void sw_model(
    input  ref_seq_t  seq_ref,
    input  read_seq_t seq_read,
    input  ref_len_t  ref_len,
    input  read_len_t read_len,
    output score_t    best,
    output row_t      best_row,
    output col_t      best_col
);
    int    h [READ_MAX_LEN+1][REF_MAX_LEN+1];
    int    e [READ_MAX_LEN+1][REF_MAX_LEN+1];
    int    f [READ_MAX_LEN+1][REF_MAX_LEN+1];
    int    s;
    int    best_i;
    base_t rb;
    base_t qb;

    best_i   = 0;
    best_row = '0;
    best_col = '0;
    for (int i = 0; i <= READ_MAX_LEN; i++) begin
        for (int j = 0; j <= REF_MAX_LEN; j++) begin
            h[i][j] = 0;
            e[i][j] = 0;
            f[i][j] = 0;
        end
    end
    // row-major scan with strict compare gives earliest row, then earliest column
    for (int i = 1; i <= int'(read_len); i++) begin
        for (int j = 1; j <= int'(ref_len); j++) begin
            rb = seq_ref[2*REF_MAX_LEN-2*j +: 2];
            qb = seq_read[2*READ_MAX_LEN-2*i +: 2];
            s  = (rb == qb) ? int'(MATCH_SCORE) : int'(MISMATCH_SCORE);
            e[i][j] = sw_model_max(0, sw_model_max(h[i-1][j] + int'(GAP_OPEN),
                                                   e[i-1][j] + int'(GAP_EXTEND)));
            f[i][j] = sw_model_max(0, sw_model_max(h[i][j-1] + int'(GAP_OPEN),
                                                   f[i][j-1] + int'(GAP_EXTEND)));
            h[i][j] = sw_model_max(sw_model_max(0, h[i-1][j-1] + s),
                                   sw_model_max(e[i][j], f[i][j]));
            if (h[i][j] > best_i) begin
                best_i   = h[i][j];
                best_row = row_t'(i - 1);
                best_col = col_t'(j - 1);
            end
        end
    end
    best = score_t'(best_i);
endfunction

`endif

/* tb/sw_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sw_tb import sw_pkg::*; ();

    localparam int NUM_DIRECTED  = 4;
    localparam int NUM_RANDOM    = 8;
    localparam int NUM_JOBS      = NUM_DIRECTED + NUM_RANDOM;
    localparam int VALID_TIMEOUT = 100;
    localparam int READY_TIMEOUT = 20;

    typedef struct packed {
        ref_seq_t   ref_seq;
        read_seq_t  read_seq;
        ref_len_t   ref_len;
        read_len_t  read_len;
        logic [3:0] ready_delay;
        score_t     exp_score;
        row_t       exp_row;
        col_t       exp_col;
    } job_t;

    logic      clk;
    logic      rst;
    logic      i_valid;
    ref_seq_t  i_sequence_ref;
    read_seq_t i_sequence_read;
    ref_len_t  i_ref_len;
    read_len_t i_read_len;
    logic      i_ready;
    logic      o_ready;
    logic      o_valid;
    score_t    o_score;
    row_t      o_row;
    col_t      o_column;

    job_t  jobs [NUM_JOBS];
    string job_name [NUM_JOBS];
    int    err_count;
    int    run_tests;
    int    fail_tests;
    bit    timed_out;

    `include "sw_model.svh"

    sw_array_top DUT (
        .clk             (clk),
        .rst             (rst),
        .i_valid         (i_valid),
        .i_sequence_ref  (i_sequence_ref),
        .i_sequence_read (i_sequence_read),
        .i_ref_len       (i_ref_len),
        .i_read_len      (i_read_len),
        .i_ready         (i_ready),
        .o_ready         (o_ready),
        .o_valid         (o_valid),
        .o_score         (o_score),
        .o_row           (o_row),
        .o_column        (o_column)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            err_count++;
        end
    endtask

    task automatic set_job(input int n, input string name, input ref_seq_t rs,
                           input read_seq_t qs, input ref_len_t rl, input read_len_t ql,
                           input int dly, input score_t sc, input row_t row, input col_t col);
        job_name[n]         = name;
        jobs[n].ref_seq     = rs;
        jobs[n].read_seq    = qs;
        jobs[n].ref_len     = rl;
        jobs[n].read_len    = ql;
        jobs[n].ready_delay = 4'(dly);
        jobs[n].exp_score   = sc;
        jobs[n].exp_row     = row;
        jobs[n].exp_col     = col;
    endtask

    task automatic fill_table();
        ref_seq_t  rs;
        read_seq_t qs;
        ref_len_t  rl;
        read_len_t ql;
        score_t    sc;
        row_t      row;
        col_t      col;
        int        dly;
        // ACGTTGCA against itself
        set_job(0, "identical 8 bases", 32'h1BE4_0000, 16'h1BE4, 5'd8, 4'd8, 0,
                10'd8, 3'd7, 4'd7);
        // all A read, all C reference
        set_job(1, "no common base", 32'h5555_5555, 16'h0000, 5'd16, 4'd8, 2,
                10'd0, 3'd0, 4'd0);
        // GTC sits at reference offset 5
        set_job(2, "short read at offset", 32'h002D_0000, 16'hB400, 5'd16, 4'd3, 10,
                10'd3, 3'd2, 4'd7);
        // ACGTT, two extra bases, GCA
        set_job(3, "internal gap", 32'h1BC2_4000, 16'h1BE4, 5'd10, 4'd8, 5,
                10'd5, 3'd4, 4'd4);
        for (int n = NUM_DIRECTED; n < NUM_JOBS; n++) begin
            rs  = ref_seq_t'($urandom);
            rl  = ref_len_t'(1 + ($urandom % REF_MAX_LEN));
            ql  = read_len_t'(1 + ($urandom % READ_MAX_LEN));
            dly = int'($urandom % 11);
            if (n % 2 == 1) begin
                // leading reference bases with one base altered
                qs = rs[2*REF_MAX_LEN-1 -: 2*READ_MAX_LEN]
                     ^ (read_seq_t'(1) << (2 * ($urandom % READ_MAX_LEN)));
            end else begin
                qs = read_seq_t'($urandom);
            end
            sw_model(rs, qs, rl, ql, sc, row, col);
            set_job(n, "random job", rs, qs, rl, ql, dly, sc, row, col);
        end
    endtask

    task automatic run_job(input int n, output bit ok);
        int     cnt;
        score_t held_score;
        row_t   held_row;
        col_t   held_col;
        ok = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (!o_ready && cnt < READY_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!o_ready) begin
            $display("test %0d: o_ready did not rise before the job could start", n);
            ok = 1'b0;
            return;
        end
        @(posedge clk);
        i_sequence_ref  <= jobs[n].ref_seq;
        i_sequence_read <= jobs[n].read_seq;
        i_ref_len       <= jobs[n].ref_len;
        i_read_len      <= jobs[n].read_len;
        i_valid         <= 1'b1;
        @(posedge clk);
        i_valid <= 1'b0;
        @(negedge clk);
        check_value("o_ready", 32'(o_ready), 32'd0);
        cnt = 0;
        while (!o_valid && cnt < VALID_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!o_valid) begin
            $display("test %0d: o_valid did not rise within %0d cycles", n, VALID_TIMEOUT);
            ok = 1'b0;
            return;
        end
        check_value("o_score", 32'(o_score), 32'(jobs[n].exp_score));
        check_value("o_row", 32'(o_row), 32'(jobs[n].exp_row));
        check_value("o_column", 32'(o_column), 32'(jobs[n].exp_col));
        held_score = o_score;
        held_row   = o_row;
        held_col   = o_column;
        // result must hold while the consumer stalls
        for (int d = 0; d < int'(jobs[n].ready_delay); d++) begin
            @(negedge clk);
            check_value("o_valid", 32'(o_valid), 32'd1);
            check_value("o_score", 32'(o_score), 32'(held_score));
            check_value("o_row", 32'(o_row), 32'(held_row));
            check_value("o_column", 32'(o_column), 32'(held_col));
        end
        @(posedge clk);
        i_ready <= 1'b1;
        @(posedge clk);
        i_ready <= 1'b0;
        @(negedge clk);
        check_value("o_valid", 32'(o_valid), 32'd0);
        cnt = 0;
        while (!o_ready && cnt < READY_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!o_ready) begin
            $display("test %0d: o_ready did not return after the result was taken", n);
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input int n, input string name, input int errs_before);
        run_tests++;
        if (err_count != errs_before) begin
            fail_tests++;
            $display("test %0d (%s): %0d mismatches", n, name, err_count - errs_before);
        end else begin
            $display("test %0d (%s): ok", n, name);
        end
    endtask

    initial begin
        int errs_before;
        bit ok;
        clk             = 1'b0;
        rst             = 1'b1;
        i_valid         = 1'b0;
        i_sequence_ref  = '0;
        i_sequence_read = '0;
        i_ref_len       = '0;
        i_read_len      = '0;
        i_ready         = 1'b0;
        err_count       = 0;
        run_tests       = 0;
        fail_tests      = 0;
        timed_out       = 1'b0;
        void'($urandom(10058));
        fill_table();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        errs_before = err_count;
        check_value("o_ready", 32'(o_ready), 32'd1);
        check_value("o_valid", 32'(o_valid), 32'd0);
        check_value("o_score", 32'(o_score), 32'd0);
        check_value("o_row", 32'(o_row), 32'd0);
        check_value("o_column", 32'(o_column), 32'd0);
        report_test(0, "reset values", errs_before);
        for (int n = 0; n < NUM_JOBS; n++) begin
            errs_before = err_count;
            run_job(n, ok);
            if (!ok) begin
                timed_out = 1'b1;
                run_tests++;
                fail_tests++;
                $display("test %0d (%s): aborted on timeout", n + 1, job_name[n]);
                break;
            end
            report_test(n + 1, job_name[n], errs_before);
        end
        $display("tests run %0d, failed %0d, mismatches %0d", run_tests, fail_tests, err_count);
        if (timed_out || err_count != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
hw/sw_pkg.sv
hw/pe_link_if.sv
hw/sw_feeder.sv
hw/sw_pe.sv
hw/sw_max_select.sv
hw/sw_array_top.sv
tb/sw_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Smith-Waterman testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module sw_tb -Mdir obj_dir -o sw_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sw_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
